/* verilog.f */
+incdir+design
design/timer_pkg.sv
design/report_pkg.sv
design/trigger_synchronizer.sv
design/duration_meter.sv
design/binary_to_bcd.sv
design/report_sequencer.sv
design/serial_transmitter.sv
design/duration_timer_top.sv
tb/clock_gen.sv
tb/duration_timer_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run; pass only if the testbench printed its pass line
verilator --binary --timing -j 0 --top-module duration_timer_tb -f verilog.f -o sim \
	&& ./obj_dir/sim | tee /dev/stderr | grep -qx "TEST OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb/duration_timer_tb.sv */
/*
 * duration timer testbench with directed report tests, serial line decoder,
 * channel model, lfsr stimulus and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

`include "timer_cfg.svh"

module duration_timer_tb;

	localparam int channels = `TIMER_CHANNELS;
	localparam int digits = `TIMER_DIGITS;
	localparam int baud = `TIMER_BAUD_DIVISOR;
	localparam int clock_period = 100;
	localparam int count_max = (1 << `TIMER_COUNT_WIDTH) - 1;
	localparam int line_length = 2 * digits + 5;
	// frame plus handover per character and two conversions per line
	localparam int report_cycles = channels * (line_length * (10 * baud + 8) + 2 * 40);
	localparam int long_pulse = count_max + 4465;
	localparam int timeout_cycles = 16 + 7 * report_cycles + long_pulse + 8 * 320 + 20000;

	logic                clock;
	logic                reset;
	logic [channels-1:0] trigger;
	logic                report_request;
	logic                tx;
	logic                report_busy;

	int          value_errors; // wrong characters or levels
	int          other_errors; // framing, missing or extra characters
	logic [31:0] lfsr_state;
	int          model_duration [channels];
	int          model_count [channels];
	logic [7:0]  received [$];
	logic [7:0]  expected [$];

	clock_gen clocks (
		.clock (clock),
		.reset (reset)
	);

	duration_timer_top DUT (
		.clock          (clock),
		.reset          (reset),
		.trigger        (trigger),
		.report_request (report_request),
		.tx             (tx),
		.report_busy    (report_busy)
	);

	// galois lfsr stepped once for every bit taken
	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return value;
	endfunction

	// decoder samples each bit near its middle on a falling edge
	initial begin : line_decoder
		logic [7:0] character;
		forever begin
			@(negedge clock);
			if (!reset && tx == 1'b0) begin
				repeat (baud / 2) @(negedge clock);
				if (tx !== 1'b0) begin
					$display("start bit on tx too short at %0t", $time);
					other_errors++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (baud) @(negedge clock);
					character[i] = tx; // lsb first
				end
				repeat (baud) @(negedge clock);
				if (tx !== 1'b1) begin
					$display("stop bit missing on tx at %0t", $time);
					other_errors++;
				end
				received.push_back(character);
			end
		end
	end

	task automatic append_decimal(input int value);
		int divisor;
		divisor = 1;
		repeat (digits - 1) divisor = divisor * 10;
		while (divisor > 0) begin
			expected.push_back(8'h30 + 8'((value / divisor) % 10)); // ascii digit
			divisor = divisor / 10;
		end
	endtask

	// one line per channel from the model
	task automatic build_expected();
		expected.delete();
		for (int ch = 0; ch < channels; ch++) begin
			expected.push_back(8'h30 + 8'(ch));
			expected.push_back(8'h20);
			append_decimal(model_duration[ch]);
			expected.push_back(8'h20);
			append_decimal(model_count[ch]);
			expected.push_back(8'h0d);
			expected.push_back(8'h0a);
		end
	endtask

	task automatic record_pulse(input int channel, input int length);
		model_duration[channel] = (length > count_max) ? count_max : length;
		if (model_count[channel] < count_max) begin
			model_count[channel]++;
		end
	endtask

	task automatic compare_report();
		int shared;
		shared = (received.size() < expected.size()) ? received.size() : expected.size();
		for (int i = 0; i < shared; i++) begin
			if (received[i] !== expected[i]) begin
				$display("[ERROR] tx character %0d: expected %h, got %h",
					i, expected[i], received[i]);
				value_errors++;
			end
		end
		if (received.size() != expected.size()) begin
			$display("report has the wrong length: expected %0d characters, received %0d",
				expected.size(), received.size());
			other_errors++;
		end
		received.delete();
	endtask

	task automatic pulse_request();
		@(negedge clock);
		report_request = 1'b1;
		@(negedge clock);
		report_request = 1'b0;
	endtask

	task automatic start_report();
		build_expected();
		received.delete();
		pulse_request();
		if (report_busy !== 1'b1) begin
			$display("[ERROR] report_busy: expected 1, got %h", report_busy);
			value_errors++;
		end
	endtask

	task automatic finish_report();
		while (report_busy) begin
			@(negedge clock);
		end
		repeat (2) @(negedge clock);
		compare_report();
	endtask

	task automatic run_report();
		start_report();
		finish_report();
	endtask

	// trigger high for exactly length clock cycles and a wait for the meter result
	task automatic drive_pulse(input int channel, input int length);
		@(negedge clock);
		trigger[channel] = 1'b1;
		repeat (length) @(negedge clock);
		trigger[channel] = 1'b0;
		repeat (4) @(negedge clock);
		record_pulse(channel, length);
	endtask

	task automatic idle_after_reset();
		bit flagged;
		flagged = 1'b0;
		repeat (200) begin
			@(negedge clock);
			if (!flagged && tx !== 1'b1) begin
				$display("[ERROR] tx: expected 1, got %h", tx);
				value_errors++;
				flagged = 1'b1;
			end
			if (!flagged && report_busy !== 1'b0) begin
				$display("[ERROR] report_busy: expected 0, got %h", report_busy);
				value_errors++;
				flagged = 1'b1;
			end
		end
		run_report(); // all zero
	endtask

	task automatic single_pulse_report();
		drive_pulse(0, 37);
		run_report();
	endtask

	// random starts and lengths on several channels per round so pulses overlap
	task automatic random_overlapping_pulses();
		int                  start [channels];
		int                  length [channels];
		logic [31:0]         bits;
		logic [channels-1:0] chosen;
		int                  span;
		for (int round = 0; round < 6; round++) begin
			bits = random_bits(channels);
			chosen = bits[channels-1:0];
			if (chosen == '0) begin
				chosen[int'(random_bits($clog2(channels)))] = 1'b1;
			end
			span = 0;
			for (int ch = 0; ch < channels; ch++) begin
				start[ch] = int'(random_bits(5));
				length[ch] = int'(random_bits(8)) + 1;
				if (chosen[ch] && start[ch] + length[ch] > span) begin
					span = start[ch] + length[ch];
				end
			end
			for (int t = 0; t < span; t++) begin
				@(negedge clock);
				for (int ch = 0; ch < channels; ch++) begin
					trigger[ch] = chosen[ch] && t >= start[ch] && t < start[ch] + length[ch];
				end
			end
			@(negedge clock);
			trigger = '0;
			repeat (4) @(negedge clock);
			for (int ch = 0; ch < channels; ch++) begin
				if (chosen[ch]) begin
					record_pulse(ch, length[ch]);
				end
			end
		end
		run_report();
	endtask

	task automatic saturated_long_pulse();
		drive_pulse(2, long_pulse); // duration sticks at the maximum
		run_report();
	endtask

	task automatic request_during_report();
		start_report();
		drive_pulse(1, 20); // lands after the snapshot and stays out of this report
		repeat (100) @(negedge clock);
		pulse_request();
		if (report_busy !== 1'b1) begin
			$display("[ERROR] report_busy: expected 1, got %h", report_busy);
			value_errors++;
		end
		finish_report();
		repeat (300) @(negedge clock);
		if (received.size() != 0 || report_busy !== 1'b0) begin
			$display("a request during an active report started another report");
			other_errors++;
		end
		run_report();
	endtask

	initial begin : watchdog
		#(timeout_cycles * clock_period);
		$display("timeout: the tests did not finish in %0d cycles", timeout_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		trigger = '0;
		report_request = 1'b0;
		value_errors = 0;
		other_errors = 0;
		lfsr_state = 32'h58c3;
		for (int ch = 0; ch < channels; ch++) begin
			model_duration[ch] = 0;
			model_count[ch] = 0;
		end
		@(negedge reset);
		@(negedge clock);
		idle_after_reset();
		single_pulse_report();
		random_overlapping_pulses();
		saturated_long_pulse();
		request_during_report();
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
/*
 * testbench clock of 100 ns period and a 16 cycle reset
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int period = 100,
	parameter int reset_cycles = 16
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever begin
			#(period / 2) clock = ~clock;
		end
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // released on a falling edge
	end

endmodule

`default_nettype wire

/* design/duration_timer_top.sv */
/*
 * multi-channel pulse duration timer with serial text report
 */
`timescale 1ns/1ps
`default_nettype none

`include "timer_cfg.svh"

module duration_timer_top (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [`TIMER_CHANNELS-1:0] trigger,
	input  logic                       report_request,
	output logic                       tx,
	output logic                       report_busy
);

	timer_pkg::trigger_event_t [`TIMER_CHANNELS-1:0]  events;
	timer_pkg::channel_result_t [`TIMER_CHANNELS-1:0] results;
	logic                                             bcd_start;
	timer_pkg::count_t                                bcd_value;
	logic                                             bcd_done;
	report_pkg::bcd_t                                 bcd_digits;
	logic                                             send;
	report_pkg::serial_byte_t                         data;
	logic                                             tx_busy;

	trigger_synchronizer synchronizer (
		.clock   (clock),
		.reset   (reset),
		.trigger (trigger),
		.events  (events)
	);

	for (genvar i = 0; i < `TIMER_CHANNELS; i++) begin : meters
		duration_meter meter (
			.clock         (clock),
			.reset         (reset),
			.trigger_event (events[i]),
			.result        (results[i])
		);
	end

	report_sequencer sequencer (
		.clock          (clock),
		.reset          (reset),
		.report_request (report_request),
		.results        (results),
		.report_busy    (report_busy),
		.bcd_start      (bcd_start),
		.bcd_value      (bcd_value),
		.bcd_done       (bcd_done),
		.bcd_digits     (bcd_digits),
		.send           (send),
		.data           (data),
		.tx_busy        (tx_busy)
	);

	binary_to_bcd converter (
		.clock  (clock),
		.reset  (reset),
		.start  (bcd_start),
		.value  (bcd_value),
		.done   (bcd_done),
		.digits (bcd_digits)
	);

	serial_transmitter transmitter (
		.clock (clock),
		.reset (reset),
		.send  (send),
		.data  (data),
		.tx    (tx),
		.busy  (tx_busy)
	);

endmodule

`default_nettype wire

/* design/serial_transmitter.sv */
/*
 * 8N1 serial transmitter, fixed baud divisor
 * busy from the cycle after send until the stop bit ends
 */
`timescale 1ns/1ps
`default_nettype none

`include "timer_cfg.svh"

module serial_transmitter (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     send,
	input  report_pkg::serial_byte_t data,
	output logic                     tx,
	output logic                     busy
);

	localparam int baud_width = $clog2(`TIMER_BAUD_DIVISOR);

	typedef logic [baud_width-1:0] baud_t;

	localparam baud_t baud_last = baud_t'(`TIMER_BAUD_DIVISOR - 1);

	baud_t      baud_count;
	logic [3:0] bit_index; // 0 start, 1..8 data, 9 stop
	logic [9:0] frame;     // bit 0 drives the line

	assign tx = frame[0];

	always_ff @(posedge clock) begin
		if (reset) begin
			frame <= '1; // idle high
			busy <= 1'b0;
			baud_count <= '0;
			bit_index <= '0;
		end else if (!busy) begin
			if (send) begin
				frame <= {1'b1, data, 1'b0}; // stop, data lsb first, start
				busy <= 1'b1;
				baud_count <= '0;
				bit_index <= '0;
			end
		end else if (baud_count == baud_last) begin
			baud_count <= '0;
			frame <= {1'b1, frame[9:1]}; // ones fill in behind the stop bit
			bit_index <= bit_index + 1'b1;
			if (bit_index == 4'd9) begin
				busy <= 1'b0;
			end
		end else begin
			baud_count <= baud_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/report_sequencer.sv */
/*
 * report FSM: snapshots all channel results on request
 * and prints one ascii line per channel through converter and transmitter
 */
`timescale 1ns/1ps
`default_nettype none

`include "timer_cfg.svh"

module report_sequencer (
	input  logic                                            clock,
	input  logic                                            reset,
	input  logic                                            report_request,
	input  timer_pkg::channel_result_t [`TIMER_CHANNELS-1:0] results,
	output logic                                            report_busy,
	output logic                                            bcd_start,
	output timer_pkg::count_t                               bcd_value,
	input  logic                                            bcd_done,
	input  report_pkg::bcd_t                                bcd_digits,
	output logic                                            send,
	output report_pkg::serial_byte_t                        data,
	input  logic                                            tx_busy
);

	// line is: channel, space, duration digits, space, count digits, cr, lf
	localparam int line_length = 2 * `TIMER_DIGITS + 5;
	localparam int position_width = $clog2(line_length);
	localparam int channel_width = $clog2(`TIMER_CHANNELS);
	localparam int slot_width = $clog2(`TIMER_DIGITS);

	typedef logic [position_width-1:0] position_t;
	typedef logic [channel_width-1:0] channel_t;
	typedef logic [slot_width-1:0] slot_t;

	localparam position_t pos_channel = position_t'(0);
	localparam position_t pos_duration = position_t'(2);
	localparam position_t pos_gap = position_t'(2 + `TIMER_DIGITS);
	localparam position_t pos_count = position_t'(3 + `TIMER_DIGITS);
	localparam position_t pos_cr = position_t'(3 + 2 * `TIMER_DIGITS);
	localparam position_t pos_lf = position_t'(4 + 2 * `TIMER_DIGITS);
	localparam channel_t last_channel = channel_t'(`TIMER_CHANNELS - 1);

	typedef enum logic [2:0] {
		state_idle,
		state_prepare,
		state_wait_bcd,
		state_send,
		state_wait_busy_high,
		state_wait_busy_low
	} state_t;

	state_t                                            state;
	timer_pkg::channel_result_t [`TIMER_CHANNELS-1:0] snapshot;
	channel_t                                          channel;
	position_t                                         position;
	slot_t                                             slot;
	report_pkg::serial_byte_t                          next_char;

	always_ff @(posedge clock) begin
		if (state == state_idle && report_request) begin
			snapshot <= results; // frozen for the whole report
		end
	end

	// character for the current position, digits msd first
	always_comb begin
		slot = '0;
		next_char = report_pkg::ascii_space;
		if (position == pos_channel) begin
			next_char = report_pkg::ascii_zero + report_pkg::serial_byte_t'(channel);
		end else if (position >= pos_duration && position < pos_gap) begin
			slot = slot_t'(pos_gap - position - 1'b1);
			next_char = report_pkg::ascii_zero + {4'h0, bcd_digits[slot]};
		end else if (position >= pos_count && position < pos_cr) begin
			slot = slot_t'(pos_cr - position - 1'b1);
			next_char = report_pkg::ascii_zero + {4'h0, bcd_digits[slot]};
		end else if (position == pos_cr) begin
			next_char = report_pkg::ascii_cr;
		end else if (position == pos_lf) begin
			next_char = report_pkg::ascii_lf;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
			report_busy <= 1'b0;
			bcd_start <= 1'b0;
			bcd_value <= '0;
			send <= 1'b0;
			data <= '0;
			channel <= '0;
			position <= '0;
		end else begin
			bcd_start <= 1'b0;
			send <= 1'b0;
			case (state)
				state_idle: begin
					if (report_request) begin
						report_busy <= 1'b1;
						channel <= '0;
						position <= '0;
						state <= state_prepare;
					end
				end
				state_prepare: begin
					if (position == pos_duration || position == pos_count) begin
						bcd_start <= 1'b1; // convert right before the digits go out
						bcd_value <= (position == pos_duration) ?
							snapshot[channel].last_duration : snapshot[channel].pulse_count;
						state <= state_wait_bcd;
					end else begin
						data <= next_char;
						state <= state_send;
					end
				end
				state_wait_bcd: begin
					if (bcd_done) begin
						data <= next_char;
						state <= state_send;
					end
				end
				state_send: begin
					if (!tx_busy) begin
						send <= 1'b1;
						state <= state_wait_busy_high;
					end
				end
				state_wait_busy_high: begin
					if (tx_busy) begin
						state <= state_wait_busy_low;
					end
				end
				state_wait_busy_low: begin
					if (!tx_busy) begin // character fully out
						if (position != pos_lf) begin
							position <= position + 1'b1;
							state <= state_prepare;
						end else if (channel != last_channel) begin
							position <= '0;
							channel <= channel + 1'b1;
							state <= state_prepare;
						end else begin
							report_busy <= 1'b0;
							state <= state_idle;
						end
					end
				end
				default: begin
					state <= state_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/binary_to_bcd.sv */
/*
 * sequential double dabble converter, one input bit per cycle
 * start strobe in, done pulse out after count width plus one cycles
 */
`timescale 1ns/1ps
`default_nettype none

`include "timer_cfg.svh"

module binary_to_bcd (
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	input  timer_pkg::count_t  value,
	output logic               done,
	output report_pkg::bcd_t   digits
);

	localparam int left_width = $clog2(`TIMER_COUNT_WIDTH + 1);

	typedef logic [left_width-1:0] left_t;

	left_t                               bits_left;
	timer_pkg::count_t                   value_shift;
	logic [`TIMER_DIGITS*4-1:0]          adjusted;

	// add three to every digit of five or more before the shift
	function automatic report_pkg::bcd_t add_three(input report_pkg::bcd_t current);
		report_pkg::bcd_t fixed;
		fixed = current;
		for (int i = 0; i < `TIMER_DIGITS; i++) begin
			if (fixed[i] >= 4'd5) begin
				fixed[i] = fixed[i] + 4'd3;
			end
		end
		return fixed;
	endfunction

	assign adjusted = add_three(digits);

	always_ff @(posedge clock) begin
		if (reset) begin
			bits_left <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				bits_left <= left_t'(`TIMER_COUNT_WIDTH);
			end else if (bits_left != '0) begin
				bits_left <= bits_left - 1'b1;
				done <= (bits_left == left_t'(1)); // last bit goes in this cycle
			end
		end
	end

	// digits stay put from done until the next start
	always_ff @(posedge clock) begin
		if (start) begin
			value_shift <= value;
			digits <= '0;
		end else if (bits_left != '0) begin
			value_shift <= value_shift << 1;
			digits <= {adjusted[`TIMER_DIGITS*4-2:0], value_shift[`TIMER_COUNT_WIDTH-1]};
		end
	end

endmodule

`default_nettype wire

/* design/duration_meter.sv */
/*
 * high time counter for one channel
 * keeps the last pulse duration and a pulse count, both saturating
 */
`timescale 1ns/1ps
`default_nettype none

module duration_meter (
	input  logic                       clock,
	input  logic                       reset,
	input  timer_pkg::trigger_event_t  trigger_event,
	output timer_pkg::channel_result_t result
);

	localparam timer_pkg::count_t count_max = '1;

	timer_pkg::count_t running_count; // cycles high so far in this pulse

	always_ff @(posedge clock) begin
		if (reset) begin
			running_count <= '0;
			result <= '0;
		end else if (trigger_event.fall) begin
			// level is already low here, so running_count is the full length
			result.last_duration <= running_count;
			if (result.pulse_count != count_max) begin
				result.pulse_count <= result.pulse_count + 1'b1;
			end
			running_count <= '0;
		end else if (trigger_event.level) begin
			if (running_count != count_max) begin // stick at the top
				running_count <= running_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/trigger_synchronizer.sv */
/*
 * two flop synchronizer for all trigger inputs
 * with falling edge detection per channel
 */
`timescale 1ns/1ps
`default_nettype none

`include "timer_cfg.svh"

module trigger_synchronizer (
	input  logic                                          clock,
	input  logic                                          reset,
	input  logic [`TIMER_CHANNELS-1:0]                    trigger,
	output timer_pkg::trigger_event_t [`TIMER_CHANNELS-1:0] events
);

	logic [`TIMER_CHANNELS-1:0] sync_first;
	logic [`TIMER_CHANNELS-1:0] sync_second;
	logic [`TIMER_CHANNELS-1:0] level_previous;

	always_ff @(posedge clock) begin
		if (reset) begin
			sync_first <= '0;
			sync_second <= '0;
			level_previous <= '0;
		end else begin
			sync_first <= trigger;
			sync_second <= sync_first; // level, two cycles behind the pin
			level_previous <= sync_second;
		end
	end

	// high in the previous cycle and low now
	always_comb begin
		for (int i = 0; i < `TIMER_CHANNELS; i++) begin
			events[i].level = sync_second[i];
			events[i].fall = level_previous[i] & ~sync_second[i];
		end
	end

endmodule

`default_nettype wire

/* design/report_pkg.sv */
/*
 * report text types: bcd digit vector, serial character
 * plus the ascii constants used when formatting lines
 */
`default_nettype none

`include "timer_cfg.svh"

package report_pkg;

	// most significant digit in the top nibble
	typedef logic [`TIMER_DIGITS-1:0][3:0] bcd_t;

	typedef logic [7:0] serial_byte_t;

	localparam serial_byte_t ascii_space = 8'h20;
	localparam serial_byte_t ascii_cr = 8'h0d;
	localparam serial_byte_t ascii_lf = 8'h0a;
	localparam serial_byte_t ascii_zero = 8'h30; // digits are zero plus value

endpackage

`default_nettype wire

/* design/timer_pkg.sv */
/*
 * measurement types: count, per-channel trigger event, channel result
 */
`default_nettype none

`include "timer_cfg.svh"

package timer_pkg;

	// durations and pulse counts share one width
	typedef logic [`TIMER_COUNT_WIDTH-1:0] count_t;

	typedef struct packed {
		logic level; // synchronized trigger
		logic fall;  // one cycle, first low cycle after high
	} trigger_event_t;

	typedef struct packed {
		count_t last_duration; // cycles high in latest pulse
		count_t pulse_count;   // completed pulses
	} channel_result_t;

endpackage

`default_nettype wire

/* design/timer_cfg.svh */
/*
 * build-time configuration of the duration timer
 * channel count, counter width, printed digits, serial baud divisor
 */
`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

// number of trigger inputs
`define TIMER_CHANNELS 4

// width of durations and pulse counts
`define TIMER_COUNT_WIDTH 16

// decimal digits per printed value, 5 covers 65535
`define TIMER_DIGITS 5

// clock cycles per serial bit
`define TIMER_BAUD_DIVISOR 8

`endif
